// ==== list.f ====
verilog/mem_pkg.sv
verilog/cpu_pkg.sv
verilog/spm_port_if.sv
verilog/stage_if.sv
verilog/fetch_stage.sv
verilog/decode_stage.sv
verilog/gpr.sv
verilog/execute_stage.sv
verilog/memory_stage.sv
verilog/spm.sv
verilog/pipeline_cpu_top.sv
testbench/tb_pipeline_cpu.sv

// ==== testbench/tb_pipeline_cpu.sv ====
`timescale 1ns/1ps

module tb_pipeline_cpu;
    import mem_pkg::*;
    import cpu_pkg::*;

    logic                      clk = 1'b0;
    logic                      rst;
    logic                      cpu_en;
    logic [spm_addr_width-1:0] test_addr;
    logic                      test_req;
    logic                      test_we;
    logic [word_width-1:0]     test_wr_data;
    logic [word_width-1:0]     test_rd_data;
    logic                      halted;

    logic [31:0] seed = 32'hdbd0;
    logic [31:0] image [spm_depth];       // words 0..511 get loaded
    logic [31:0] expect_mem [spm_depth];
    logic [31:0] ref_regs [gpr_num];
    int          gen_pc;
    int          mismatches = 0;
    int          failures = 0;
    logic        cmp_valid = 1'b0;
    int          cmp_addr;
    logic [31:0] cmp_exp;
    logic [31:0] cmp_act;

    pipeline_cpu_top pipeline_cpu_top_i (.*);

    always #50 clk = ~clk;

    // one readback word per cycle
    always @(negedge clk) begin
        if (cmp_valid) begin
            assert (cmp_act === cmp_exp) else begin
                mismatches++;
                $display("mismatch at %0t: word %0d expected %h, got %h",
                         $time, cmp_addr, cmp_exp, cmp_act);
            end
            cmp_valid = 1'b0;
        end
    end

    function automatic int rnd(input int n);
        seed = seed * 32'd1664525 + 32'd1013904223;
        return int'(seed[30:8]) % n;
    endfunction

    function automatic logic [31:0] enc(input logic [5:0] op, input int rd, input int rs0,
                                        input int low);
        return {op, rd[4:0], rs0[4:0], low[15:0]};
    endfunction

    function automatic void emit(input logic [31:0] insn);
        image[gen_pc] = insn;
        gen_pc++;
    endfunction

    // reg-reg alu op or addi, never writes r0 or r1
    function automatic logic [31:0] simple_insn();
        int sel;
        sel = rnd(8);
        if (sel == 7) begin
            return enc(op_addi, 2 + rnd(8), rnd(10), rnd(65536));
        end
        return enc(6'(sel + 1), 2 + rnd(8), rnd(10), rnd(10) << 11);  // add through shr
    endfunction

    // byte offset from r1, sometimes misaligned
    function automatic int mem_offset();
        return 4 * rnd(256) + ((rnd(8) == 0) ? 1 + rnd(3) : 0);
    endfunction

    function automatic void build_program(input int prog);
        int kind;
        int skip;
        for (int a = 0; a < spm_depth; a++) begin
            image[a] = (a < 256) ? 32'h0 : (32'h9e3779b9 * a) ^ (a << 20) ^ (prog << 28);
        end
        gen_pc = 0;
        emit(enc(op_addi, 1, 0, 1024));  // r1 = byte address of word 256
        while (gen_pc < 180) begin
            kind = rnd(8);
            if (kind < 3) begin
                emit(simple_insn());
            end else if (kind < 5) begin
                emit(enc(op_store, rnd(10), 1, mem_offset()));
            end else if (kind < 6) begin
                emit(enc(op_load, 2 + rnd(8), 1, mem_offset()));
                emit(enc(op_addi, 2 + rnd(8), 0, rnd(256)));  // gap before any use
            end else begin
                skip = rnd(4);
                emit(enc(rnd(2) ? op_beq : op_bne, rnd(10), rnd(10), skip + 1));
                for (int i = 0; i <= skip; i++) begin
                    emit(simple_insn());  // delay slot first
                end
            end
        end
        for (int r = 2; r < 10; r++) begin
            emit(enc(op_store, r, 1, 1020 - 4 * r));
        end
        emit(enc(op_halt, 0, 0, 0));
    endfunction

    // in-order model with one delay slot
    function automatic void run_reference();
        logic [31:0] insn, s0, s1, sd, imm, addr, res;
        logic [9:0]  pc, nxt, tgt;
        logic        pend, wr;
        expect_mem = image;
        pc   = '0;
        tgt  = '0;
        pend = 1'b0;
        for (int step = 0; step < 4000; step++) begin
            insn = expect_mem[pc];
            s0   = ref_regs[insn[20:16]];
            s1   = ref_regs[insn[15:11]];
            sd   = ref_regs[insn[25:21]];
            imm  = {{16{insn[15]}}, insn[15:0]};
            addr = s0 + imm;
            nxt  = pend ? tgt : pc + 10'd1;
            pend = 1'b0;
            wr   = 1'b1;
            res  = '0;
            case (insn[31:26])
                op_add:  res = s0 + s1;
                op_sub:  res = s0 - s1;
                op_and:  res = s0 & s1;
                op_or:   res = s0 | s1;
                op_xor:  res = s0 ^ s1;
                op_shl:  res = s0 << s1[4:0];
                op_shr:  res = s0 >> s1[4:0];
                op_addi: res = addr;
                op_load: begin
                    res = expect_mem[addr[11:2]];
                    wr  = addr[1:0] == 2'b00;
                end
                op_store: begin
                    wr = 1'b0;
                    if (addr[1:0] == 2'b00) begin
                        expect_mem[addr[11:2]] = sd;
                    end
                end
                op_beq, op_bne: begin
                    wr   = 1'b0;
                    pend = (insn[31:26] == op_beq) == (s0 == sd);
                    tgt  = pc + 10'd1 + imm[9:0];
                end
                op_halt: return;
                default: wr = 1'b0;
            endcase
            if (wr && insn[25:21] != 5'd0) begin
                ref_regs[insn[25:21]] = res;
            end
            pc = nxt;
        end
    endfunction

    task automatic apply_reset();
        rst = 1'b1;
        repeat (2) @(negedge clk);
        rst    = 1'b0;
        cpu_en = 1'b0;
        for (int r = 0; r < gpr_num; r++) begin
            ref_regs[r] = '0;
        end
    endtask

    task automatic read_back(input int lo, input int hi);
        for (int a = lo; a < hi; a++) begin
            @(negedge clk);
            test_addr = a[spm_addr_width-1:0];
            test_req  = 1'b1;
            test_we   = 1'b0;
            @(posedge clk);
            cmp_addr  = a;
            cmp_exp   = expect_mem[a];
            cmp_act   = test_rd_data;
            cmp_valid = 1'b1;
        end
        @(negedge clk);
        test_req = 1'b0;
    endtask

    task automatic load_image();
        for (int a = 0; a < 512; a++) begin
            @(negedge clk);
            test_addr    = a[spm_addr_width-1:0];
            test_req     = 1'b1;
            test_we      = 1'b1;
            test_wr_data = image[a];
        end
        expect_mem = image;
        read_back(0, 512);
    endtask

    task automatic finish_run();
        @(negedge clk);
        @(posedge clk);  // last readback still in flight
        $display("errors: %0d mismatches, %0d other failures", mismatches, failures);
        if (mismatches == 0 && failures == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    endtask

    task automatic wait_halted();
        int n;
        n = 0;
        while (!halted && n < 4000) begin
            @(negedge clk);
            n++;
        end
        assert (halted) else begin
            failures++;
            $display("halted never rose within %0d cycles", n);
        end
    endtask

    task automatic run_program();
        @(negedge clk);
        cpu_en = 1'b1;
        wait_halted();
        cpu_en = 1'b0;
        @(negedge clk);
        assert (!halted) else begin
            failures++;
            $display("halted stayed high after cpu_en dropped");
        end
    endtask

    initial begin
        rst          = 1'b1;
        cpu_en       = 1'b0;
        test_addr    = '0;
        test_req     = 1'b0;
        test_we      = 1'b0;
        test_wr_data = '0;
        apply_reset();
        // registers carry over between programs
        for (int prog = 0; prog < 4; prog++) begin
            build_program(prog);
            load_image();
            run_reference();
            run_program();
            read_back(256, 512);
        end
        build_program(4);
        load_image();
        @(negedge clk);
        cpu_en = 1'b1;
        wait_halted();
        apply_reset();  // cpu still enabled while rst is high
        assert (!halted) else begin
            failures++;
            $display("halted is high after a reset with the cpu enabled");
        end
        load_image();
        run_reference();
        run_program();
        read_back(256, 512);
        finish_run();
    end
endmodule

// ==== verilog/cpu_pkg.sv ====
package cpu_pkg;

    typedef enum logic [5:0] {
        op_nop   = 6'd0,
        op_add   = 6'd1,
        op_sub   = 6'd2,
        op_and   = 6'd3,
        op_or    = 6'd4,
        op_xor   = 6'd5,
        op_shl   = 6'd6,
        op_shr   = 6'd7,
        op_addi  = 6'd8,
        op_load  = 6'd9,
        op_store = 6'd10,
        op_beq   = 6'd11,
        op_bne   = 6'd12,
        op_halt  = 6'd13
    } opcode_t;

    typedef enum logic [3:0] {
        alu_pass, alu_add, alu_sub, alu_and, alu_or, alu_xor, alu_shl, alu_shr
    } alu_op_t;

    typedef enum logic [1:0] {
        mem_none, mem_load, mem_store
    } mem_op_t;

    localparam int gpr_num        = 32;
    localparam int gpr_addr_width = 5;

    // instruction fields
    localparam int op_hi  = 31;
    localparam int op_lo  = 26;
    localparam int rd_hi  = 25;
    localparam int rd_lo  = 21;
    localparam int rs0_hi = 20;
    localparam int rs0_lo = 16;
    localparam int rs1_hi = 15;
    localparam int rs1_lo = 11;
    localparam int imm_hi = 15;  // overlaps rs1, sign extended
    localparam int imm_lo = 0;

endpackage

// ==== verilog/decode_stage.sv ====
`timescale 1ns/1ps

module decode_stage (
    input  logic                                clk,
    input  logic                                rst,
    input  logic                                if_valid,
    input  logic [mem_pkg::pc_width-1:0]        if_pc,
    input  logic [mem_pkg::word_width-1:0]      if_insn,
    output logic [cpu_pkg::gpr_addr_width-1:0]  gpr_rd_addr_0,
    output logic [cpu_pkg::gpr_addr_width-1:0]  gpr_rd_addr_1,
    input  logic [mem_pkg::word_width-1:0]      gpr_rd_data_0,
    input  logic [mem_pkg::word_width-1:0]      gpr_rd_data_1,
    input  logic                                ex_fwd_we,
    input  logic [cpu_pkg::gpr_addr_width-1:0]  ex_fwd_dst,
    input  logic [mem_pkg::word_width-1:0]      ex_fwd_data,
    input  logic                                mem_fwd_we,
    input  logic [cpu_pkg::gpr_addr_width-1:0]  mem_fwd_dst,
    input  logic [mem_pkg::word_width-1:0]      mem_fwd_data,
    output logic                                br_taken,
    output logic [mem_pkg::pc_width-1:0]        br_addr,
    output logic                                halt_seen,
    id_ex_if.producer                           id_ex
);
    import mem_pkg::*;
    import cpu_pkg::*;

    opcode_t                   op;
    logic [gpr_addr_width-1:0] rd;
    logic [gpr_addr_width-1:0] rs0;
    logic [gpr_addr_width-1:0] rs1;
    logic [word_width-1:0]     imm;
    logic [word_width-1:0]     op_0;
    logic [word_width-1:0]     op_1;
    alu_op_t                   alu_op;
    mem_op_t                   mem_op;
    logic                      use_imm;
    logic                      wr_en;

    // youngest producer wins, register file last
    function automatic logic [word_width-1:0] pick(
        input logic [gpr_addr_width-1:0] addr,
        input logic [word_width-1:0]     file_data
    );
        return (ex_fwd_we && ex_fwd_dst == addr) ? ex_fwd_data :
               (mem_fwd_we && mem_fwd_dst == addr) ? mem_fwd_data : file_data;
    endfunction

    assign op  = opcode_t'(if_insn[op_hi:op_lo]);
    assign rd  = if_insn[rd_hi:rd_lo];
    assign rs0 = if_insn[rs0_hi:rs0_lo];
    assign rs1 = if_insn[rs1_hi:rs1_lo];
    assign imm = {{(word_width - imm_hi - 1){if_insn[imm_hi]}}, if_insn[imm_hi:imm_lo]};

    // store data and branch compare come from rd
    assign gpr_rd_addr_0 = rs0;
    assign gpr_rd_addr_1 = (op inside {op_store, op_beq, op_bne}) ? rd : rs1;

    always_comb begin
        op_0 = pick(rs0, gpr_rd_data_0);
        op_1 = pick(gpr_rd_addr_1, gpr_rd_data_1);
    end

    always_comb begin
        case (op)
            op_add, op_addi, op_load, op_store: alu_op = alu_add;
            op_sub: alu_op = alu_sub;
            op_and: alu_op = alu_and;
            op_or:  alu_op = alu_or;
            op_xor: alu_op = alu_xor;
            op_shl: alu_op = alu_shl;
            op_shr: alu_op = alu_shr;
            default: alu_op = alu_pass;  // unknown opcodes end up as nop
        endcase
    end

    assign use_imm = op inside {op_addi, op_load, op_store};
    assign wr_en   = op inside {op_add, op_sub, op_and, op_or, op_xor, op_shl, op_shr,
                                op_addi, op_load};
    assign mem_op  = (op == op_load) ? mem_load : (op == op_store) ? mem_store : mem_none;

    assign br_taken  = if_valid && ((op == op_beq && op_0 == op_1) ||
                                    (op == op_bne && op_0 != op_1));
    assign br_addr   = if_pc + pc_width'(1) + imm[pc_width-1:0];
    assign halt_seen = if_valid && op == op_halt;

    always_ff @(posedge clk) begin
        if (rst || !if_valid) begin
            id_ex.valid  <= 1'b0;
            id_ex.we     <= 1'b0;
            id_ex.mem_op <= mem_none;
            id_ex.halt   <= 1'b0;
        end else begin
            id_ex.valid  <= 1'b1;
            id_ex.we     <= wr_en && rd != '0;  // r0 is never a target
            id_ex.mem_op <= mem_op;
            id_ex.halt   <= halt_seen;
        end
    end

    always_ff @(posedge clk) begin
        id_ex.alu_op     <= alu_op;
        id_ex.alu_in_0   <= op_0;
        id_ex.alu_in_1   <= use_imm ? imm : op_1;
        id_ex.store_data <= op_1;
        id_ex.dst        <= rd;
    end
endmodule

// ==== verilog/execute_stage.sv ====
`timescale 1ns/1ps

module execute_stage (
    input  logic                                clk,
    input  logic                                rst,
    id_ex_if.consumer                           id_ex,
    ex_mem_if.producer                          ex_mem,
    output logic                                ex_fwd_we,
    output logic [cpu_pkg::gpr_addr_width-1:0]  ex_fwd_dst,
    output logic [mem_pkg::word_width-1:0]      ex_fwd_data
);
    import mem_pkg::*;
    import cpu_pkg::*;

    logic [word_width-1:0] alu_out;

    always_comb begin
        case (id_ex.alu_op)
            alu_add: alu_out = id_ex.alu_in_0 + id_ex.alu_in_1;
            alu_sub: alu_out = id_ex.alu_in_0 - id_ex.alu_in_1;
            alu_and: alu_out = id_ex.alu_in_0 & id_ex.alu_in_1;
            alu_or:  alu_out = id_ex.alu_in_0 | id_ex.alu_in_1;
            alu_xor: alu_out = id_ex.alu_in_0 ^ id_ex.alu_in_1;
            alu_shl: alu_out = id_ex.alu_in_0 << id_ex.alu_in_1[4:0];  // low five bits
            alu_shr: alu_out = id_ex.alu_in_0 >> id_ex.alu_in_1[4:0];
            default: alu_out = id_ex.alu_in_0;
        endcase
    end

    // a load only has its address here
    assign ex_fwd_we   = id_ex.valid && id_ex.we && id_ex.mem_op != mem_load;
    assign ex_fwd_dst  = id_ex.dst;
    assign ex_fwd_data = alu_out;

    always_ff @(posedge clk) begin
        if (rst) begin
            ex_mem.valid  <= 1'b0;
            ex_mem.we     <= 1'b0;
            ex_mem.mem_op <= mem_none;
            ex_mem.halt   <= 1'b0;
        end else begin
            ex_mem.valid  <= id_ex.valid;
            ex_mem.we     <= id_ex.we;
            ex_mem.mem_op <= id_ex.mem_op;
            ex_mem.halt   <= id_ex.halt;
        end
    end

    always_ff @(posedge clk) begin
        ex_mem.result     <= alu_out;
        ex_mem.store_data <= id_ex.store_data;
        ex_mem.dst        <= id_ex.dst;
    end
endmodule

// ==== verilog/fetch_stage.sv ====
`timescale 1ns/1ps

module fetch_stage (
    input  logic                            clk,
    input  logic                            rst,
    input  logic                            cpu_en,
    input  logic                            br_taken,
    input  logic [mem_pkg::pc_width-1:0]    br_addr,
    input  logic                            halt_seen,
    spm_port_if.requester                   imem,
    output logic                            if_valid,
    output logic [mem_pkg::pc_width-1:0]    if_pc,
    output logic [mem_pkg::word_width-1:0]  if_insn
);
    import mem_pkg::*;

    logic [pc_width-1:0] pc;
    logic                frozen;  // halt already passed decode

    // port a only ever reads
    assign imem.addr    = pc;
    assign imem.req     = cpu_en;
    assign imem.we      = 1'b0;
    assign imem.wr_data = '0;

    always_ff @(posedge clk) begin
        if (rst || !cpu_en) begin
            pc       <= '0;
            frozen   <= 1'b0;
            if_valid <= 1'b0;
        end else if (halt_seen || frozen) begin
            frozen   <= 1'b1;  // pc holds, bubbles from here on
            if_valid <= 1'b0;
        end else begin
            pc       <= br_taken ? br_addr : pc + pc_width'(1);
            if_valid <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if_pc   <= pc;
        if_insn <= imem.rd_data;
    end

    // decode only sees bubbles once fetch is frozen
    a_no_branch_when_frozen: assert property (
        @(posedge clk) disable iff (rst) frozen |-> !br_taken
    );
endmodule

// ==== verilog/gpr.sv ====
`timescale 1ns/1ps

module gpr (
    input  logic                                clk,
    input  logic                                rst,
    input  logic                                we,
    input  logic [cpu_pkg::gpr_addr_width-1:0]  wr_addr,
    input  logic [mem_pkg::word_width-1:0]      wr_data,
    input  logic [cpu_pkg::gpr_addr_width-1:0]  rd_addr_0,
    input  logic [cpu_pkg::gpr_addr_width-1:0]  rd_addr_1,
    output logic [mem_pkg::word_width-1:0]      rd_data_0,
    output logic [mem_pkg::word_width-1:0]      rd_data_1
);
    import mem_pkg::*;
    import cpu_pkg::*;

    logic [word_width-1:0] regs [gpr_num];

    function automatic logic [word_width-1:0] read_reg(input logic [gpr_addr_width-1:0] addr);
        if (addr == '0) begin
            return '0;
        end
        return (we && wr_addr == addr) ? wr_data : regs[addr];  // writeback bypass
    endfunction

    always_comb begin
        rd_data_0 = read_reg(rd_addr_0);
        rd_data_1 = read_reg(rd_addr_1);
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < gpr_num; i++) begin
                regs[i] <= '0;
            end
        end else if (we) begin
            regs[wr_addr] <= wr_data;
        end
    end

    // decode drops r0 as a target
    a_no_r0_write: assert property (@(posedge clk) disable iff (rst) we |-> wr_addr != '0);
endmodule

// ==== verilog/mem_pkg.sv ====
package mem_pkg;

    localparam int word_width     = 32;
    localparam int spm_depth      = 1024;  // words
    localparam int spm_addr_width = 10;    // word index into the spm
    localparam int pc_width       = 10;    // pc counts words, not bytes

endpackage

// ==== verilog/memory_stage.sv ====
`timescale 1ns/1ps

module memory_stage (
    input  logic                                clk,
    input  logic                                rst,
    input  logic                                cpu_en,
    ex_mem_if.consumer                          ex_mem,
    spm_port_if.requester                       dmem,
    input  logic [mem_pkg::spm_addr_width-1:0]  test_addr,
    input  logic                                test_req,
    input  logic                                test_we,
    input  logic [mem_pkg::word_width-1:0]      test_wr_data,
    output logic [mem_pkg::word_width-1:0]      test_rd_data,
    output logic                                mem_fwd_we,
    output logic [cpu_pkg::gpr_addr_width-1:0]  mem_fwd_dst,
    output logic [mem_pkg::word_width-1:0]      mem_fwd_data,
    output logic                                wb_we,
    output logic [cpu_pkg::gpr_addr_width-1:0]  wb_dst,
    output logic [mem_pkg::word_width-1:0]      wb_data,
    output logic                                halted
);
    import mem_pkg::*;
    import cpu_pkg::*;

    logic misaligned;
    logic is_load;
    logic pipe_req;

    assign misaligned = ex_mem.result[1:0] != 2'b00;
    assign is_load    = ex_mem.mem_op == mem_load;
    assign pipe_req   = ex_mem.valid && ex_mem.mem_op != mem_none && !misaligned;

    // port b goes to the test port while the cpu is off
    assign dmem.addr    = cpu_en ? ex_mem.result[spm_addr_width+1:2] : test_addr;
    assign dmem.req     = cpu_en ? pipe_req : test_req;
    assign dmem.we      = cpu_en ? (ex_mem.mem_op == mem_store) : test_we;
    assign dmem.wr_data = cpu_en ? ex_mem.store_data : test_wr_data;
    assign test_rd_data = cpu_en ? '0 : dmem.rd_data;

    assign mem_fwd_we   = ex_mem.valid && ex_mem.we && !(is_load && misaligned);
    assign mem_fwd_dst  = ex_mem.dst;
    assign mem_fwd_data = is_load ? dmem.rd_data : ex_mem.result;

    always_ff @(posedge clk) begin
        if (rst) begin
            wb_we  <= 1'b0;
            halted <= 1'b0;
        end else begin
            wb_we <= mem_fwd_we;
            if (!cpu_en) begin
                halted <= 1'b0;
            end else if (ex_mem.valid && ex_mem.halt) begin
                halted <= 1'b1;  // older stores already written
            end
        end
    end

    always_ff @(posedge clk) begin
        wb_dst  <= ex_mem.dst;
        wb_data <= mem_fwd_data;
    end

    // pipeline is drained once halted is up
    a_no_access_after_halt: assert property (
        @(posedge clk) disable iff (rst)
        cpu_en && halted |-> !dmem.req
    );
endmodule

// ==== verilog/pipeline_cpu_top.sv ====
`timescale 1ns/1ps

module pipeline_cpu_top (
    input  logic                                clk,
    input  logic                                rst,
    input  logic                                cpu_en,
    input  logic [mem_pkg::spm_addr_width-1:0]  test_addr,
    input  logic                                test_req,
    input  logic                                test_we,
    input  logic [mem_pkg::word_width-1:0]      test_wr_data,
    output logic [mem_pkg::word_width-1:0]      test_rd_data,
    output logic                                halted
);
    import mem_pkg::*;
    import cpu_pkg::*;

    logic                      if_valid;
    logic [pc_width-1:0]       if_pc;
    logic [word_width-1:0]     if_insn;
    logic                      br_taken;
    logic [pc_width-1:0]       br_addr;
    logic                      halt_seen;
    logic [gpr_addr_width-1:0] gpr_rd_addr_0;
    logic [gpr_addr_width-1:0] gpr_rd_addr_1;
    logic [word_width-1:0]     gpr_rd_data_0;
    logic [word_width-1:0]     gpr_rd_data_1;
    logic                      ex_fwd_we;
    logic [gpr_addr_width-1:0] ex_fwd_dst;
    logic [word_width-1:0]     ex_fwd_data;
    logic                      mem_fwd_we;
    logic [gpr_addr_width-1:0] mem_fwd_dst;
    logic [word_width-1:0]     mem_fwd_data;
    logic                      wb_we;
    logic [gpr_addr_width-1:0] wb_dst;
    logic [word_width-1:0]     wb_data;

    spm_port_if imem ();  // port a, instruction fetch
    spm_port_if dmem ();  // port b, data or test port
    id_ex_if    id_ex ();
    ex_mem_if   ex_mem ();

    fetch_stage   u_fetch_stage (.*);
    decode_stage  u_decode_stage (.*);
    execute_stage u_execute_stage (.*);
    memory_stage  u_memory_stage (.*);

    gpr u_gpr (
        .clk       (clk),
        .rst       (rst),
        .we        (wb_we),
        .wr_addr   (wb_dst),
        .wr_data   (wb_data),
        .rd_addr_0 (gpr_rd_addr_0),
        .rd_addr_1 (gpr_rd_addr_1),
        .rd_data_0 (gpr_rd_data_0),
        .rd_data_1 (gpr_rd_data_1)
    );

    spm u_spm (
        .clk    (clk),
        .port_a (imem),
        .port_b (dmem)
    );
endmodule

// ==== verilog/spm.sv ====
`timescale 1ns/1ps

module spm (
    input  logic        clk,
    spm_port_if.memory  port_a,
    spm_port_if.memory  port_b
);
    import mem_pkg::*;

    logic [word_width-1:0] mem [spm_depth];

    // both ports read in the same cycle
    assign port_a.rd_data = port_a.req ? mem[port_a.addr] : '0;
    assign port_b.rd_data = port_b.req ? mem[port_b.addr] : '0;

    // instruction side has no write path
    always_ff @(posedge clk) begin
        if (port_b.req && port_b.we) begin
            mem[port_b.addr] <= port_b.wr_data;
        end
    end
endmodule

// ==== verilog/spm_port_if.sv ====
`timescale 1ns/1ps

interface spm_port_if;
    import mem_pkg::*;

    logic [spm_addr_width-1:0] addr;
    logic                      req;
    logic                      we;  // write at the edge when req is also high
    logic [word_width-1:0]     wr_data;
    logic [word_width-1:0]     rd_data;  // same cycle as addr

    modport requester (
        output addr, req, we, wr_data,
        input  rd_data
    );

    modport memory (
        input  addr, req, we, wr_data,
        output rd_data
    );
endinterface

// ==== verilog/stage_if.sv ====
`timescale 1ns/1ps

// decode register, read by execute
interface id_ex_if;
    import mem_pkg::*;
    import cpu_pkg::*;

    logic                      valid;
    alu_op_t                   alu_op;
    logic [word_width-1:0]     alu_in_0;
    logic [word_width-1:0]     alu_in_1;
    mem_op_t                   mem_op;
    logic [word_width-1:0]     store_data;
    logic [gpr_addr_width-1:0] dst;
    logic                      we;
    logic                      halt;

    modport producer (output valid, alu_op, alu_in_0, alu_in_1, mem_op, store_data, dst, we, halt);
    modport consumer (input valid, alu_op, alu_in_0, alu_in_1, mem_op, store_data, dst, we, halt);
endinterface

// execute register, read by the memory stage
interface ex_mem_if;
    import mem_pkg::*;
    import cpu_pkg::*;

    logic                      valid;
    logic [word_width-1:0]     result;  // byte address for loads and stores
    mem_op_t                   mem_op;
    logic [word_width-1:0]     store_data;
    logic [gpr_addr_width-1:0] dst;
    logic                      we;
    logic                      halt;

    modport producer (output valid, result, mem_op, store_data, dst, we, halt);
    modport consumer (input valid, result, mem_op, store_data, dst, we, halt);
endinterface
